// File: include/secure_bus_defs.svh
// Bus widths and synchronizer depth for the secure bus bridge
// The wide bus must be exactly twice the narrow bus
`ifndef SECURE_BUS_DEFS_SVH
`define SECURE_BUS_DEFS_SVH

// Data widths in bits
`define SB_NARROW_DW 32
`define SB_WIDE_DW 64

// Byte address width
`define SB_AW 32

// Isolate request synchronizer depth
`define SB_SYNC_STAGES 3

`endif

// File: design/secure_bus_pkg.sv
// Bus types and isolator states shared by the bridge RTL
// Widths come from the defines header
`default_nettype none

`include "secure_bus_defs.svh"

package secure_bus_pkg;

   typedef logic [`SB_AW-1:0]          addr_t;
   typedef logic [`SB_NARROW_DW-1:0]   narrow_data_t;
   typedef logic [`SB_WIDE_DW-1:0]     wide_data_t;

   // One select bit per byte lane
   typedef logic [`SB_NARROW_DW/8-1:0] narrow_sel_t;
   typedef logic [`SB_WIDE_DW/8-1:0]   wide_sel_t;

   typedef enum logic [1:0] {
      ISO_RUN,
      ISO_DRAIN,
      ISO_ISOLATED
   } iso_state_t;

endpackage

`default_nettype wire

// File: design/wb_if.sv
// Wishbone classic link, one cycle in flight
// No clock inside, both ends sample on their own clock
`timescale 1ns/10ps
`default_nettype none

interface wb_if #(
   parameter type data_t = secure_bus_pkg::wide_data_t,
   parameter type sel_t  = secure_bus_pkg::wide_sel_t
);

   // Request side
   logic                  cyc;
   logic                  stb;
   logic                  we;
   secure_bus_pkg::addr_t adr;
   data_t                 dat_w;
   sel_t                  sel;

   // Response side
   data_t                 dat_r;
   logic                  ack;
   logic                  err;

   modport master (
      output cyc, stb, we, adr, dat_w, sel,
      input  dat_r, ack, err
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w, sel,
      output dat_r, ack, err
   );

endinterface

`default_nettype wire

// File: design/wb_upsizer.sv
// Registered 32-to-64-bit Wishbone classic upsizer, one cycle in flight
// Upstream master must drop stb in the cycle after ack or err
`timescale 1ns/10ps
`default_nettype none

module wb_upsizer (
   input  wire logic                         clk_i,
   input  wire logic                         rst_n_i,
   input  wire logic                         up_cyc_i,
   input  wire logic                         up_stb_i,
   input  wire logic                         up_we_i,
   input  wire secure_bus_pkg::addr_t        up_adr_i,
   input  wire secure_bus_pkg::narrow_data_t up_dat_i,
   input  wire secure_bus_pkg::narrow_sel_t  up_sel_i,
   output secure_bus_pkg::narrow_data_t      up_dat_o,
   output logic                              up_ack_o,
   output logic                              up_err_o,
   wb_if.master                              mid
);

   localparam int unsigned NDW      = $bits(secure_bus_pkg::narrow_data_t);
   localparam int unsigned NSW      = $bits(secure_bus_pkg::narrow_sel_t);
   localparam int unsigned LANE_BIT = $clog2(NSW);

   logic                         busy_q;
   logic                         ack_q;
   logic                         err_q;
   logic                         lane_q;
   logic                         we_q;
   secure_bus_pkg::addr_t        adr_q;
   secure_bus_pkg::wide_data_t   dat_q;
   secure_bus_pkg::wide_sel_t    sel_q;
   secure_bus_pkg::narrow_data_t rdata_q;
   logic                         accept;
   logic                         done;

   // No new request while one is open or its response is still showing
   assign accept = up_cyc_i & up_stb_i & ~busy_q & ~ack_q & ~err_q;
   assign done   = busy_q & (mid.ack | mid.err);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
      end else begin
         ack_q <= done & mid.ack;
         err_q <= done & mid.err;
         if (accept) begin
            busy_q <= 1'b1;
         end else if (done) begin
            busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         lane_q <= up_adr_i[LANE_BIT];
         we_q   <= up_we_i;
         adr_q  <= up_adr_i;
         // Write data goes to both halves, selects pick the lane
         dat_q  <= {up_dat_i, up_dat_i};
         if (up_adr_i[LANE_BIT]) begin
            sel_q <= {up_sel_i, {NSW{1'b0}}};
         end else begin
            sel_q <= {{NSW{1'b0}}, up_sel_i};
         end
      end
      if (done) begin
         rdata_q <= mid.dat_r[lane_q*NDW +: NDW];
      end
   end

   assign mid.cyc   = busy_q;
   assign mid.stb   = busy_q;
   assign mid.we    = we_q;
   assign mid.adr   = adr_q;
   assign mid.dat_w = dat_q;
   assign mid.sel   = sel_q;

   assign up_dat_o = rdata_q;
   assign up_ack_o = ack_q;
   assign up_err_o = err_q;

endmodule

`default_nettype wire

// File: design/bus_isolator.sv
// Wishbone isolator, terminates cycles with err while isolated
// Starts isolated, isolate_i may be asynchronous to clk_i
`timescale 1ns/10ps
`default_nettype none

`include "secure_bus_defs.svh"

module bus_isolator (
   input  wire logic                       clk_i,
   input  wire logic                       rst_n_i,
   wb_if.slave                             mid,
   output logic                            dn_cyc_o,
   output logic                            dn_stb_o,
   output logic                            dn_we_o,
   output secure_bus_pkg::addr_t           dn_adr_o,
   output secure_bus_pkg::wide_data_t      dn_dat_o,
   output secure_bus_pkg::wide_sel_t       dn_sel_o,
   input  wire secure_bus_pkg::wide_data_t dn_dat_i,
   input  wire logic                       dn_ack_i,
   input  wire logic                       dn_err_i,
   input  wire logic                       isolate_i,
   output logic                            isolated_o
);

   logic [`SB_SYNC_STAGES-1:0] iso_sync_q;
   logic                       iso_req;
   secure_bus_pkg::iso_state_t state_q;
   secure_bus_pkg::iso_state_t state_d;
   logic                       pass;
   logic                       open_cyc;
   logic                       dn_done;
   logic                       term_err_q;

   // Synchronizer resets high so the bus comes up isolated
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         iso_sync_q <= '1;
      end else begin
         iso_sync_q <= {iso_sync_q[`SB_SYNC_STAGES-2:0], isolate_i};
      end
   end

   assign iso_req  = iso_sync_q[`SB_SYNC_STAGES-1];
   assign open_cyc = mid.cyc & mid.stb;
   assign dn_done  = dn_ack_i | dn_err_i;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         secure_bus_pkg::ISO_RUN: begin
            if (iso_req) begin
               // Let an unfinished downstream cycle run to its end
               if (open_cyc && !dn_done) begin
                  state_d = secure_bus_pkg::ISO_DRAIN;
               end else begin
                  state_d = secure_bus_pkg::ISO_ISOLATED;
               end
            end
         end
         secure_bus_pkg::ISO_DRAIN: begin
            if (dn_done) begin
               state_d = secure_bus_pkg::ISO_ISOLATED;
            end
         end
         secure_bus_pkg::ISO_ISOLATED: begin
            if (!iso_req && !open_cyc) begin
               state_d = secure_bus_pkg::ISO_RUN;
            end
         end
         default: state_d = secure_bus_pkg::ISO_ISOLATED;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= secure_bus_pkg::ISO_ISOLATED;
         term_err_q <= 1'b0;
      end else begin
         state_q    <= state_d;
         // One-cycle err pulse per terminated request
         term_err_q <= (state_q == secure_bus_pkg::ISO_ISOLATED) & open_cyc & ~term_err_q;
      end
   end

   // Drain only ever carries the cycle that was open on entry
   assign pass = (state_q != secure_bus_pkg::ISO_ISOLATED);

   assign dn_cyc_o = pass & mid.cyc;
   assign dn_stb_o = pass & mid.stb;
   assign dn_we_o  = mid.we;
   assign dn_adr_o = mid.adr;
   assign dn_dat_o = mid.dat_w;
   assign dn_sel_o = mid.sel;

   assign mid.dat_r = dn_dat_i;
   assign mid.ack   = pass & dn_ack_i;
   assign mid.err   = pass ? dn_err_i : term_err_q;

   assign isolated_o = (state_q == secure_bus_pkg::ISO_ISOLATED);

endmodule

`default_nettype wire

// File: design/secure_bus_bridge.sv
// Outbound secure bus path, 32-bit Wishbone in, 64-bit Wishbone out
// Comes out of reset isolated, every access ends with err until released
`timescale 1ns/10ps
`default_nettype none

module secure_bus_bridge (
   input  wire logic                         clk_i,
   input  wire logic                         rst_n_i,
   // Narrow upstream
   input  wire logic                         up_cyc_i,
   input  wire logic                         up_stb_i,
   input  wire logic                         up_we_i,
   input  wire secure_bus_pkg::addr_t        up_adr_i,
   input  wire secure_bus_pkg::narrow_data_t up_dat_i,
   input  wire secure_bus_pkg::narrow_sel_t  up_sel_i,
   output secure_bus_pkg::narrow_data_t      up_dat_o,
   output logic                              up_ack_o,
   output logic                              up_err_o,
   // Wide downstream
   output logic                              dn_cyc_o,
   output logic                              dn_stb_o,
   output logic                              dn_we_o,
   output secure_bus_pkg::addr_t             dn_adr_o,
   output secure_bus_pkg::wide_data_t        dn_dat_o,
   output secure_bus_pkg::wide_sel_t         dn_sel_o,
   input  wire secure_bus_pkg::wide_data_t   dn_dat_i,
   input  wire logic                         dn_ack_i,
   input  wire logic                         dn_err_i,
   // Isolation control
   input  wire logic                         isolate_i,
   output logic                              isolated_o
);

   wb_if #(
      .data_t ( secure_bus_pkg::wide_data_t ),
      .sel_t  ( secure_bus_pkg::wide_sel_t  )
   ) wb_mid ();

   wb_upsizer i_wb_upsizer (
      .clk_i    ( clk_i    ),
      .rst_n_i  ( rst_n_i  ),
      .up_cyc_i ( up_cyc_i ),
      .up_stb_i ( up_stb_i ),
      .up_we_i  ( up_we_i  ),
      .up_adr_i ( up_adr_i ),
      .up_dat_i ( up_dat_i ),
      .up_sel_i ( up_sel_i ),
      .up_dat_o ( up_dat_o ),
      .up_ack_o ( up_ack_o ),
      .up_err_o ( up_err_o ),
      .mid      ( wb_mid   )
   );

   bus_isolator i_bus_isolator (
      .clk_i      ( clk_i      ),
      .rst_n_i    ( rst_n_i    ),
      .mid        ( wb_mid     ),
      .dn_cyc_o   ( dn_cyc_o   ),
      .dn_stb_o   ( dn_stb_o   ),
      .dn_we_o    ( dn_we_o    ),
      .dn_adr_o   ( dn_adr_o   ),
      .dn_dat_o   ( dn_dat_o   ),
      .dn_sel_o   ( dn_sel_o   ),
      .dn_dat_i   ( dn_dat_i   ),
      .dn_ack_i   ( dn_ack_i   ),
      .dn_err_i   ( dn_err_i   ),
      .isolate_i  ( isolate_i  ),
      .isolated_o ( isolated_o )
   );

endmodule

`default_nettype wire

// File: test/secure_bus_properties.sv
// Wishbone rules on the downstream side of the isolator
// Bound into every bus_isolator instance
`timescale 1ns/10ps
`default_nettype none

module secure_bus_properties (
   input wire logic clk_i,
   input wire logic rst_n_i,
   input wire logic dn_cyc_i,
   input wire logic dn_stb_i,
   input wire logic dn_ack_i,
   input wire logic dn_err_i,
   input wire logic iso_req_i
);

   stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dn_stb_i |-> dn_cyc_i)
      else $error("dn_stb_o is high while dn_cyc_o is low");

   ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(dn_ack_i && dn_err_i))
      else $error("dn_ack_i and dn_err_i are high together");

   // Once isolation is requested no new downstream cycle may start
   no_cyc_isolated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iso_req_i && !dn_cyc_i |=> !dn_cyc_i)
      else $error("dn_cyc_o started while isolation was requested");

endmodule

bind bus_isolator secure_bus_properties i_secure_bus_properties (
   .clk_i     ( clk_i    ),
   .rst_n_i   ( rst_n_i  ),
   .dn_cyc_i  ( dn_cyc_o ),
   .dn_stb_i  ( dn_stb_o ),
   .dn_ack_i  ( dn_ack_i ),
   .dn_err_i  ( dn_err_i ),
   .iso_req_i ( iso_req  )
);

`default_nettype wire

// File: test/tb_secure_bus_bridge.sv
// Testbench for the secure bus bridge, inputs change on the falling clock edge
// Downstream memory covers 1 KiB, higher addresses alias into it
`timescale 1ns/10ps
`default_nettype none

`include "secure_bus_defs.svh"

module tb_secure_bus_bridge;

   localparam int unsigned TB_TIMEOUT = 200;
   localparam int unsigned MEM_LINES  = 128;

   logic                         clk_i;
   logic                         rst_n_i;
   logic                         up_cyc_i;
   logic                         up_stb_i;
   logic                         up_we_i;
   secure_bus_pkg::addr_t        up_adr_i;
   secure_bus_pkg::narrow_data_t up_dat_i;
   secure_bus_pkg::narrow_sel_t  up_sel_i;
   secure_bus_pkg::narrow_data_t up_dat_o;
   logic                         up_ack_o;
   logic                         up_err_o;
   logic                         dn_cyc_o;
   logic                         dn_stb_o;
   logic                         dn_we_o;
   secure_bus_pkg::addr_t        dn_adr_o;
   secure_bus_pkg::wide_data_t   dn_dat_o;
   secure_bus_pkg::wide_sel_t    dn_sel_o;
   secure_bus_pkg::wide_data_t   dn_dat_i = '0;
   logic                         dn_ack_i = 1'b0;
   logic                         dn_err_i = 1'b0;
   logic                         isolate_i;
   logic                         isolated_o;

   secure_bus_pkg::wide_data_t   mem [MEM_LINES];
   secure_bus_pkg::narrow_data_t shadow [2*MEM_LINES];
   secure_bus_pkg::wide_sel_t    last_sel = '0;
   int unsigned                  max_wait;
   int unsigned                  hold_cycles;
   int unsigned                  next_wait = 0;
   int unsigned                  wait_cnt = 0;
   logic                         mem_active = 1'b0;
   int unsigned                  dn_cyc_count = 0;
   int unsigned                  checks;
   int unsigned                  errors;
   int unsigned                  test_start;

   secure_bus_bridge dut0 (.*);

   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      if (dn_cyc_o === 1'b1) begin
         dn_cyc_count <= dn_cyc_count + 1;
      end
   end

   // 64-bit memory, answers after hold_cycles or a random number of wait states
   always @(negedge clk_i) begin
      if (dn_ack_i) begin
         dn_ack_i = 1'b0;
      end else if (dn_cyc_o && dn_stb_o) begin
         if (!mem_active) begin
            mem_active = 1'b1;
            wait_cnt   = (hold_cycles != 0) ? hold_cycles : next_wait;
         end
         if (wait_cnt != 0) begin
            wait_cnt = wait_cnt - 1;
         end else begin
            if (dn_we_o) begin
               for (int b = 0; b < 8; b++) begin
                  if (dn_sel_o[b]) begin
                     mem[dn_adr_o[9:3]][8*b +: 8] = dn_dat_o[8*b +: 8];
                  end
               end
               last_sel = dn_sel_o;
            end
            dn_dat_i   = mem[dn_adr_o[9:3]];
            dn_ack_i   = 1'b1;
            mem_active = 1'b0;
         end
      end
   end

   function automatic secure_bus_pkg::narrow_data_t fill_word(input secure_bus_pkg::addr_t a);
      return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
   endfunction

   function automatic secure_bus_pkg::narrow_data_t expected_read(
      input secure_bus_pkg::addr_t a
   );
      return shadow[a[9:2]];
   endfunction

   task automatic shadow_write(input secure_bus_pkg::addr_t a,
                               input secure_bus_pkg::narrow_data_t d,
                               input secure_bus_pkg::narrow_sel_t s);
      for (int b = 0; b < 4; b++) begin
         if (s[b]) begin
            shadow[a[9:2]][8*b +: 8] = d[8*b +: 8];
         end
      end
   endtask

   task automatic check_data(input string name, input secure_bus_pkg::narrow_data_t exp,
                             input secure_bus_pkg::narrow_data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_sel(input string name, input secure_bus_pkg::wide_sel_t exp,
                            input secure_bus_pkg::wide_sel_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic timeout_abort(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Test failed");
      $finish;
   endtask

   task automatic end_test(input string name);
      $display("%s done with %0d errors", name, errors - test_start);
      test_start = errors;
   endtask

   task automatic bus_access(input logic we, input secure_bus_pkg::addr_t adr,
                             input secure_bus_pkg::narrow_data_t dat,
                             input secure_bus_pkg::narrow_sel_t sel,
                             output secure_bus_pkg::narrow_data_t rdata,
                             output logic ack, output logic err);
      int unsigned cnt;
      next_wait = $urandom % (max_wait + 1);
      @(negedge clk_i);
      up_cyc_i = 1'b1;
      up_stb_i = 1'b1;
      up_we_i  = we;
      up_adr_i = adr;
      up_dat_i = dat;
      up_sel_i = sel;
      cnt      = 0;
      while (!up_ack_o && !up_err_o) begin
         if (cnt == TB_TIMEOUT) begin
            timeout_abort("the end of an upstream cycle");
         end
         @(negedge clk_i);
         cnt++;
      end
      ack      = up_ack_o;
      err      = up_err_o;
      rdata    = up_dat_o;
      up_cyc_i = 1'b0;
      up_stb_i = 1'b0;
      up_we_i  = 1'b0;
   endtask

   task automatic write_word(input string name, input secure_bus_pkg::addr_t adr,
                             input secure_bus_pkg::narrow_data_t dat,
                             input secure_bus_pkg::narrow_sel_t sel, input logic exp_ack);
      secure_bus_pkg::narrow_data_t rd;
      logic                         ack;
      logic                         err;
      bus_access(1'b1, adr, dat, sel, rd, ack, err);
      check_flag({name, " ack"}, exp_ack, ack);
      check_flag({name, " err"}, ~exp_ack, err);
      if (exp_ack) begin
         shadow_write(adr, dat, sel);
      end
   endtask

   task automatic read_word(input string name, input secure_bus_pkg::addr_t adr,
                            input logic exp_ack);
      secure_bus_pkg::narrow_data_t rd;
      logic                         ack;
      logic                         err;
      bus_access(1'b0, adr, '0, '1, rd, ack, err);
      check_flag({name, " ack"}, exp_ack, ack);
      check_flag({name, " err"}, ~exp_ack, err);
      if (exp_ack) begin
         check_data(name, expected_read(adr), rd);
      end
   endtask

   initial begin
      secure_bus_pkg::addr_t        a;
      secure_bus_pkg::narrow_data_t d;
      secure_bus_pkg::narrow_sel_t  s;
      int unsigned                  cnt;
      int unsigned                  cyc_before;

      void'($urandom(46367));
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      up_cyc_i    = 1'b0;
      up_stb_i    = 1'b0;
      up_we_i     = 1'b0;
      up_adr_i    = '0;
      up_dat_i    = '0;
      up_sel_i    = '0;
      isolate_i   = 1'b1;
      max_wait    = 0;
      hold_cycles = 0;
      checks      = 0;
      errors      = 0;
      test_start  = 0;
      for (int i = 0; i < MEM_LINES; i++) begin
         mem[i] = {fill_word(i*8 + 4), fill_word(i*8)};
      end
      for (int i = 0; i < 2*MEM_LINES; i++) begin
         shadow[i] = fill_word(i*4);
      end
      repeat (10) @(negedge clk_i);
      rst_n_i = 1'b1;

      check_flag("isolated after reset", 1'b1, isolated_o);
      check_flag("ack low after reset", 1'b0, up_ack_o | up_err_o);
      check_flag("dn_cyc low after reset", 1'b0, dn_cyc_o | dn_stb_o);
      cyc_before = dn_cyc_count;
      write_word("isolated write", 32'h10, 32'hdead_beef, 4'hf, 1'b0);
      read_word("isolated read", 32'h14, 1'b0);
      check_flag("dn_cyc stays low", 1'b1, dn_cyc_count == cyc_before);
      end_test("reset_isolated");

      isolate_i = 1'b0;
      cnt       = 0;
      while (isolated_o) begin
         if (cnt == TB_TIMEOUT) begin
            timeout_abort("isolated_o to fall");
         end
         @(negedge clk_i);
         cnt++;
      end
      check_flag("release latency", 1'b1, cnt <= `SB_SYNC_STAGES + 1);
      write_word("low word write", 32'h40, 32'h0123_4567, 4'hf, 1'b1);
      write_word("high word write", 32'h44, 32'h89ab_cdef, 4'hf, 1'b1);
      read_word("low word read", 32'h40, 1'b1);
      read_word("high word read", 32'h44, 1'b1);
      end_test("release_readback");

      for (int i = 0; i < 2; i++) begin
         a = 32'h80 + i*4;
         s = 4'b1011;
         write_word("lane write", a, 32'h5555_aaaa, s, 1'b1);
         check_sel("lane sel", a[2] ? {s, 4'h0} : {4'h0, s}, last_sel);
      end
      end_test("lane_select");

      write_word("full write", 32'h100, 32'h1122_3344, 4'hf, 1'b1);
      write_word("merge write", 32'h100, 32'haabb_ccdd, 4'b0101, 1'b1);
      read_word("merge read", 32'h100, 1'b1);
      write_word("top byte write", 32'h104, 32'h9988_7766, 4'b1000, 1'b1);
      read_word("top byte read", 32'h104, 1'b1);
      read_word("neighbour read", 32'h100, 1'b1);
      end_test("partial_merge");

      max_wait = 4;
      repeat (200) begin
         a = ($urandom % 256) << 2;
         d = $urandom;
         s = $urandom % 16;
         if ($urandom % 2) begin
            write_word("random write", a, d, s, 1'b1);
         end else begin
            read_word("random read", a, 1'b1);
         end
      end
      end_test("random_traffic");

      // Isolate request arrives while the memory holds the cycle open
      hold_cycles = 20;
      fork
         write_word("drained write", 32'h200, 32'hcafe_f00d, 4'hf, 1'b1);
         begin
            cnt = 0;
            while (!dn_cyc_o) begin
               if (cnt == TB_TIMEOUT) begin
                  timeout_abort("the downstream cycle to start");
               end
               @(negedge clk_i);
               cnt++;
            end
            isolate_i = 1'b1;
         end
      join
      hold_cycles = 0;
      cnt         = 0;
      while (!isolated_o) begin
         if (cnt == TB_TIMEOUT) begin
            timeout_abort("isolated_o to rise");
         end
         @(negedge clk_i);
         cnt++;
      end
      // Isolation takes effect as soon as the drained cycle ends
      check_flag("isolate latency after drain", 1'b1, cnt <= 1);
      read_word("read after isolate", 32'h200, 1'b0);
      write_word("write after isolate", 32'h208, 32'h0bad_0bad, 4'hf, 1'b0);
      end_test("isolate_drain");

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/secure_bus_pkg.sv
design/wb_if.sv
design/wb_upsizer.sv
design/bus_isolator.sv
design/secure_bus_bridge.sv
test/secure_bus_properties.sv
test/tb_secure_bus_bridge.sv

// File: Bender.yml
package:
  name: secure_bus_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/secure_bus_pkg.sv
      - design/wb_if.sv
      - design/wb_upsizer.sv
      - design/bus_isolator.sv
      - design/secure_bus_bridge.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/secure_bus_properties.sv
      - test/tb_secure_bus_bridge.sv
